//--- Makefile
# Verilator build and run for the clock divider bank

VERILATOR ?= verilator
TOP       ?= tb_clk_div_bank
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
src/clk_div_pkg.sv
src/tc_clk_gating.sv
src/clk_cfg_regs.sv
src/clk_int_div.sv
src/clk_activity_monitor.sv
src/clk_div_bank.sv
testbench/clk_div_bank_asserts.sv
testbench/tb_clk_checker.sv
testbench/tb_clk_div_bank.sv

//--- src/clk_activity_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module clk_activity_monitor (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [clk_div_pkg::NumChannels-1:0]                   div_clk_i,
  output clk_div_pkg::edge_cnt_t [clk_div_pkg::NumChannels-1:0] edge_cnt_o
);

  import clk_div_pkg::*;

  // each binary bit is the xor of all gray bits at or above its position
  function automatic edge_cnt_t gray2bin(edge_cnt_t gray);
    edge_cnt_t bin;
    bin[EdgeCntWidth-1] = gray[EdgeCntWidth-1];
    for (int i = EdgeCntWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  for (genvar g = 0; g < NumChannels; g++) begin : gen_chan

    // counter in the divided clock domain, kept in binary and in gray code
    edge_cnt_t bin_q;
    edge_cnt_t bin_next;
    edge_cnt_t gray_q;
    // two stage synchronizer and the converted count in the clk_i domain
    edge_cnt_t sync1_q;
    edge_cnt_t sync2_q;
    edge_cnt_t cnt_q;

    assign bin_next = bin_q + 1'b1;

    //------------------------------------------------------------------------
    // divided clock domain
    //------------------------------------------------------------------------

    always_ff @(posedge div_clk_i[g] or negedge rst_ni) begin
      if (!rst_ni) begin
        bin_q  <= '0;
        gray_q <= '0;
      end else begin
        bin_q  <= bin_next;
        // only one bit of gray_q flips per edge, so a sample taken mid change
        // is off by at most one count
        gray_q <= bin_next ^ (bin_next >> 1);
      end
    end

    //------------------------------------------------------------------------
    // clk_i domain
    //------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        sync1_q <= '0;
        sync2_q <= '0;
        cnt_q   <= '0;
      end else begin
        sync1_q <= gray_q;
        sync2_q <= sync1_q;
        cnt_q   <= gray2bin(sync2_q);
      end
    end

    assign edge_cnt_o[g] = cnt_q;

  end

endmodule

`default_nettype wire

//--- src/clk_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clk_cfg_regs (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  cfg_we_i,
  input  clk_div_pkg::chan_idx_t                                cfg_addr_i,
  input  clk_div_pkg::chan_cfg_t                                cfg_wdata_i,
  input  logic [clk_div_pkg::NumChannels-1:0]                   div_ready_i,
  output clk_div_pkg::chan_cfg_t [clk_div_pkg::NumChannels-1:0] cfg_o,
  output logic [clk_div_pkg::NumChannels-1:0]                   div_valid_o
);

  import clk_div_pkg::*;

  // stored configuration, the factor field is also the value offered to the divider
  chan_cfg_t [NumChannels-1:0] cfg_d, cfg_q;
  // one pending flag per channel while a new factor waits for its ready
  logic [NumChannels-1:0]      pend_d, pend_q;

  //--------------------------------------------------------------------------
  // write decode
  //--------------------------------------------------------------------------

  always_comb begin
    cfg_d  = cfg_q;
    // a channel drops its request in the cycle after the divider accepts it
    pend_d = pend_q & ~div_ready_i;

    // a channel that still has a request open ignores the whole write
    if (cfg_we_i && !pend_q[cfg_addr_i]) begin
      cfg_d[cfg_addr_i].en = cfg_wdata_i.en;
      // only a real change of factor goes through the handshake
      if (cfg_wdata_i.div != cfg_q[cfg_addr_i].div) begin
        cfg_d[cfg_addr_i].div = cfg_wdata_i.div;
        pend_d[cfg_addr_i]    = 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // all channels come up disabled with the default factor
      for (int unsigned i = 0; i < NumChannels; i++) begin
        cfg_q[i].en  <= 1'b0;
        cfg_q[i].div <= div_t'(DefaultDiv);
      end
      pend_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      pend_q <= pend_d;
    end
  end

  // valid comes straight from a flop so it never depends on ready in the same cycle
  assign div_valid_o = pend_q;
  // the factor stays frozen while valid is high since writes are dropped then
  assign cfg_o       = cfg_q;

endmodule

`default_nettype wire

//--- src/clk_div_bank.sv
`timescale 1ns/1ps
`default_nettype none

module clk_div_bank (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  test_mode_en_i,
  input  logic                                                  cfg_we_i,
  input  clk_div_pkg::chan_idx_t                                cfg_addr_i,
  input  clk_div_pkg::chan_cfg_t                                cfg_wdata_i,
  output logic [clk_div_pkg::NumChannels-1:0]                   cfg_busy_o,
  output logic [clk_div_pkg::NumChannels-1:0]                   clk_o_o,
  output clk_div_pkg::edge_cnt_t [clk_div_pkg::NumChannels-1:0] edge_cnt_o
);

  import clk_div_pkg::*;

  // configuration and handshake between the register block and the dividers
  chan_cfg_t [NumChannels-1:0] cfg;
  logic [NumChannels-1:0]      div_valid;
  logic [NumChannels-1:0]      div_ready;

  //--------------------------------------------------------------------------
  // configuration registers
  //--------------------------------------------------------------------------

  clk_cfg_regs i_clk_cfg_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .div_ready_i (div_ready),
    .cfg_o       (cfg),
    .div_valid_o (div_valid)
  );

  // a channel reports busy for as long as its factor change is open
  assign cfg_busy_o = div_valid;

  //--------------------------------------------------------------------------
  // divider channels
  //--------------------------------------------------------------------------

  for (genvar g = 0; g < NumChannels; g++) begin : gen_div
    clk_int_div i_clk_int_div (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .en_i           (cfg[g].en),
      .test_mode_en_i (test_mode_en_i),
      .div_i          (cfg[g].div),
      .div_valid_i    (div_valid[g]),
      .div_ready_o    (div_ready[g]),
      .clk_o          (clk_o_o[g])
    );
  end

  // the monitor watches the same clocks that leave the bank
  clk_activity_monitor i_clk_activity_monitor (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .div_clk_i  (clk_o_o),
    .edge_cnt_o (edge_cnt_o)
  );

endmodule

`default_nettype wire

//--- src/clk_div_pkg.sv
`default_nettype none

package clk_div_pkg;

  //--------------------------------------------------------------------------
  // bank dimensions
  //--------------------------------------------------------------------------

  // number of independent divider channels sharing clk_i
  localparam int unsigned NumChannels  = 4;
  // width of a division factor, so the largest factor is 15
  localparam int unsigned DivWidth     = 4;
  // width of the per-channel rising edge counter
  localparam int unsigned EdgeCntWidth = 8;
  // factor loaded into every channel by reset, which means clk_i pass-through
  localparam int unsigned DefaultDiv   = 1;

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  typedef logic [DivWidth-1:0]            div_t;
  typedef logic [$clog2(NumChannels)-1:0] chan_idx_t;
  typedef logic [EdgeCntWidth-1:0]        edge_cnt_t;

  // per-channel configuration, enable in the top bit and the factor below it
  typedef struct packed {
    logic en;
    div_t div;
  } chan_cfg_t;

  // load sequence of a divider channel while a new factor is taken over
  typedef enum logic [1:0] {
    IDLE,
    LOAD_DIV,
    WAIT_START_PERIOD,
    WAIT_END_PERIOD
  } gate_state_e;

endpackage

`default_nettype wire

//--- src/clk_int_div.sv
`timescale 1ns/1ps
`default_nettype none

module clk_int_div (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_i,
  input  logic              test_mode_en_i,
  input  clk_div_pkg::div_t div_i,
  input  logic              div_valid_i,
  output logic              div_ready_o,
  output logic              clk_o
);

  import clk_div_pkg::*;

  // factor in use and the values derived from it
  div_t        div_d, div_q;
  div_t        cnt_last;
  div_t        cnt_half;
  div_t        cnt_half_odd;
  // free running cycle counter in the clk_i domain
  div_t        cnt_d, cnt_q;
  logic        cnt_clear;
  // bypass for factors 0 and 1, and the odd/even select
  logic        bypass_d, bypass_q;
  logic        odd_d, odd_q;
  // gate enable produced by the load FSM
  logic        gate_en_d, gate_en_q;
  gate_state_e state_d, state_q;
  // toggle flip-flops and the clocks built from them
  logic        tff_rise_q, tff_rise_en;
  logic        tff_fall_q, tff_fall_en;
  logic        gen_clk;
  logic        ungated_clk;

  // last count of a period and the toggle points inside it
  assign cnt_last     = div_q - 1'b1;
  assign cnt_half     = div_q >> 1;
  // for an odd factor (d+1)/2 equals d/2+1 and cannot overflow the width
  assign cnt_half_odd = (div_q >> 1) + 1'b1;

  //--------------------------------------------------------------------------
  // load FSM
  //--------------------------------------------------------------------------

  always_comb begin
    div_d       = div_q;
    bypass_d    = bypass_q;
    odd_d       = odd_q;
    state_d     = state_q;
    cnt_clear   = 1'b0;
    div_ready_o = 1'b0;
    gate_en_d   = 1'b0;

    case (state_q)
      IDLE: begin
        gate_en_d = 1'b1;
        if (div_valid_i) begin
          if (div_i == div_q) begin
            // same factor again, accept at once and keep the clock running
            div_ready_o = 1'b1;
          end else begin
            // close the gate first, it takes effect with the next low phase
            gate_en_d = 1'b0;
            state_d   = LOAD_DIV;
          end
        end
      end

      LOAD_DIV: begin
        // once the ungated clock is low the closed enable sits in the gate latch
        // and the counter and factor can change without reaching clk_o
        if (!ungated_clk || bypass_q) begin
          div_d       = div_i;
          div_ready_o = 1'b1;
          cnt_clear   = 1'b1;
          odd_d       = div_i[0];
          bypass_d    = (div_i < 2);
          state_d     = WAIT_START_PERIOD;
        end
      end

      WAIT_START_PERIOD: begin
        if (cnt_q == '0) begin
          state_d = WAIT_END_PERIOD;
        end
      end

      WAIT_END_PERIOD: begin
        // one complete period of the new factor has passed behind the gate
        if ((cnt_q == cnt_last) || bypass_q) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q     <= div_t'(DefaultDiv);
      odd_q     <= (DefaultDiv % 2) == 1;
      bypass_q  <= DefaultDiv < 2;
      state_q   <= IDLE;
      // the gate stays closed in reset and opens on the first cycle after it
      gate_en_q <= 1'b0;
    end else begin
      div_q     <= div_d;
      odd_q     <= odd_d;
      bypass_q  <= bypass_d;
      state_q   <= state_d;
      gate_en_q <= gate_en_d;
    end
  end

  //--------------------------------------------------------------------------
  // cycle counter
  //--------------------------------------------------------------------------

  always_comb begin
    if (cnt_clear || bypass_q || (cnt_q == cnt_last)) begin
      cnt_d = '0;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //--------------------------------------------------------------------------
  // toggle flip-flops
  //--------------------------------------------------------------------------

  // even factors toggle twice per period on the rising edge only, odd factors
  // toggle once on each edge type and the xor of both gives the 50% duty cycle
  always_comb begin
    tff_rise_en = 1'b0;
    tff_fall_en = 1'b0;
    if (!bypass_q) begin
      if (odd_q) begin
        tff_rise_en = (cnt_q == '0);
        tff_fall_en = (cnt_q == cnt_half_odd);
      end else begin
        tff_rise_en = (cnt_q == '0) || (cnt_q == cnt_half);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tff_rise_q <= 1'b0;
    end else if (tff_rise_en) begin
      tff_rise_q <= ~tff_rise_q;
    end
  end

  // falling edge flop shifts the odd clock edges by half an input period
  always_ff @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tff_fall_q <= 1'b0;
    end else if (tff_fall_en) begin
      tff_fall_q <= ~tff_fall_q;
    end
  end

  //--------------------------------------------------------------------------
  // output clock path
  //--------------------------------------------------------------------------

  assign gen_clk     = odd_q ? (tff_rise_q ^ tff_fall_q) : tff_rise_q;
  // test mode and factors below 2 take the input clock directly
  assign ungated_clk = (bypass_q || test_mode_en_i) ? clk_i : gen_clk;

  tc_clk_gating i_clk_gate (
    .clk_i     (ungated_clk),
    .en_i      (gate_en_q & en_i),
    .test_en_i (test_mode_en_i),
    .clk_o     (clk_o)
  );

endmodule

`default_nettype wire

//--- src/tc_clk_gating.sv
`timescale 1ns/1ps
`default_nettype none

module tc_clk_gating (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // enable as seen by the and gate, frozen while the clock is high
  logic en_latched;

  // transparent only in the low phase, so a change of en_i during the high
  // phase waits for the next falling edge and cannot cut a pulse short
  always_latch begin
    if (!clk_i) begin
      en_latched <= en_i | test_en_i;
    end
  end

  // the clock can only rise while the latched enable is already stable
  assign clk_o = clk_i & en_latched;

endmodule

`default_nettype wire

//--- testbench/clk_div_bank_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module clk_div_bank_asserts (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  cfg_we_i,
  input  clk_div_pkg::chan_idx_t                                cfg_addr_i,
  input  logic [clk_div_pkg::NumChannels-1:0]                   div_valid_i,
  input  logic [clk_div_pkg::NumChannels-1:0]                   div_ready_i,
  input  clk_div_pkg::chan_cfg_t [clk_div_pkg::NumChannels-1:0] cfg_i
);

  import clk_div_pkg::*;

  // running sum of the per-channel failure counts, the last entry is the total
  int fails_part [NumChannels+1];
  int fail_cnt;

  assign fails_part[0] = 0;
  assign fail_cnt      = fails_part[NumChannels];

  for (genvar g = 0; g < NumChannels; g++) begin : gen_chan
    int fails = 0;

    // an open request stays up until the divider takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      div_valid_i[g] && !div_ready_i[g] |=> div_valid_i[g])
      else begin
        $error("valid dropped without ready on channel %0d", g);
        fails++;
      end

    // the offered factor cannot move while it waits
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      div_valid_i[g] && !div_ready_i[g] |=> $stable(cfg_i[g].div))
      else begin
        $error("factor changed under a pending valid on channel %0d", g);
        fails++;
      end

    // busy clears in the cycle after the handshake
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      div_valid_i[g] && div_ready_i[g] |=> !div_valid_i[g])
      else begin
        $error("busy still set after ready on channel %0d", g);
        fails++;
      end

    // a request only opens after a write to that channel
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(div_valid_i[g]) |-> $past(cfg_we_i && (cfg_addr_i == chan_idx_t'(g))))
      else begin
        $error("busy rose without a write on channel %0d", g);
        fails++;
      end

    assign fails_part[g+1] = fails_part[g] + fails;
  end

endmodule

bind clk_div_bank clk_div_bank_asserts i_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cfg_we_i    (cfg_we_i),
  .cfg_addr_i  (cfg_addr_i),
  .div_valid_i (div_valid),
  .div_ready_i (div_ready),
  .cfg_i       (cfg)
);

`default_nettype wire

//--- testbench/tb_clk_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_checker (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   test_mode_i,
  input  logic                                   cfg_we_i,
  input  clk_div_pkg::chan_idx_t                 cfg_addr_i,
  input  clk_div_pkg::chan_cfg_t                 cfg_wdata_i,
  input  logic [clk_div_pkg::NumChannels-1:0]    cfg_busy_i,
  input  logic [clk_div_pkg::NumChannels-1:0]    clk_div_i,
  output int                                     err_cnt_o
);

  import clk_div_pkg::*;

  // expected configuration, following only the writes that the bank accepts
  int exp_div [NumChannels];
  int old_div [NumChannels];
  bit exp_en  [NumChannels];
  int chg_cnt [NumChannels];
  // errors from direct value checks, then a running sum over the channels
  int task_errs = 0;
  int errs_part [NumChannels+1];

  assign errs_part[0] = task_errs;
  assign err_cnt_o    = errs_part[NumChannels];

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  // factors 0 and 1 pass clk_i through, any other factor divides the 8 ns clock
  function automatic real ref_period(int div);
    return (div < 2) ? 8.0 : div * 8.0;
  endfunction

  // every factor keeps a 50% duty cycle
  function automatic real ref_high(int div);
    return ref_period(div) / 2.0;
  endfunction

  function automatic real min_real(real a, real b);
    return (a < b) ? a : b;
  endfunction

  // value check used by the stimulus for edge counts and clock levels
  task automatic check_range(input string name, input int got, input int lo, input int hi);
    if (got < lo || got > hi) begin
      $display("[ERROR] %0.3f ns %s: got %0d expected %0d..%0d", $realtime, name, got, lo, hi);
      task_errs++;
    end
  endtask

  // a write to a channel with an open request is dropped by the bank
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumChannels; i++) begin
        exp_div[i] = DefaultDiv;
        old_div[i] = DefaultDiv;
        exp_en[i]  = 1'b0;
        chg_cnt[i] = 0;
      end
    end else if (cfg_we_i && !cfg_busy_i[cfg_addr_i]) begin
      old_div[cfg_addr_i] = exp_div[cfg_addr_i];
      exp_div[cfg_addr_i] = int'(cfg_wdata_i.div);
      exp_en[cfg_addr_i]  = cfg_wdata_i.en;
      chg_cnt[cfg_addr_i]++;
    end
  end

  //--------------------------------------------------------------------------
  // per-channel measurement
  //--------------------------------------------------------------------------

  for (genvar g = 0; g < NumChannels; g++) begin : gen_chk
    int  errs = 0;
    int  seen = 0;
    int  skip = 3;
    int  dis_edges = 0;
    bit  rise_ok = 0;
    bit  hi_ok = 0;
    bit  any_ok = 0;
    real now, last_rise, last_any, hi_meas, per, lim;

    always @(posedge clk_div_i[g] or negedge clk_div_i[g]) begin
      now = $realtime;
      // a new configuration restarts the measurement, the first periods are gated
      if (seen != chg_cnt[g]) begin
        seen      = chg_cnt[g];
        rise_ok   = 0;
        hi_ok     = 0;
        skip      = 3;
        dis_edges = 0;
      end
      if (test_mode_i || !rst_ni) begin
        rise_ok = 0;
        hi_ok   = 0;
        any_ok  = 0;
        skip    = 3;
      end else if (clk_div_i[g]) begin
        if (!exp_en[g]) begin
          // one edge may still be in flight when the disable arrives
          dis_edges++;
          if (dis_edges > 2) begin
            $display("%0.3f ns: clk_o_o[%0d] keeps running after it was disabled", now, g);
            errs++;
          end
        end else if (skip > 0) begin
          skip--;
        end else if (rise_ok) begin
          per = now - last_rise;
          if (per < ref_period(exp_div[g]) - 0.01 || per > ref_period(exp_div[g]) + 0.01) begin
            $display("[ERROR] %0.3f ns clk_o_o[%0d] period: got %0.3f expected %0.3f",
                     now, g, per, ref_period(exp_div[g]));
            errs++;
          end
          if (hi_ok && (hi_meas < ref_high(exp_div[g]) - 0.01 ||
                        hi_meas > ref_high(exp_div[g]) + 0.01)) begin
            $display("[ERROR] %0.3f ns clk_o_o[%0d] high time: got %0.3f expected %0.3f",
                     now, g, hi_meas, ref_high(exp_div[g]));
            errs++;
          end
        end
        last_rise = now;
        last_any  = now;
        rise_ok   = 1;
        any_ok    = 1;
        hi_ok     = 0;
      end else begin
        if (rise_ok) begin
          hi_meas = now - last_rise;
          hi_ok   = 1;
        end
        // no pulse may be shorter than half of the shorter period around a change
        lim = min_real(ref_period(old_div[g]), ref_period(exp_div[g])) / 2.0;
        if (any_ok && (now - last_any) < lim - 0.01) begin
          $display("%0.3f ns: clk_o_o[%0d] has a short pulse of %0.3f ns, shortest allowed %0.3f",
                   now, g, now - last_any, lim);
          errs++;
        end
      end
    end

    assign errs_part[g+1] = errs_part[g] + errs;
  end

endmodule

`default_nettype wire

//--- testbench/tb_clk_div_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_div_bank;

  import clk_div_pkg::*;

  //--------------------------------------------------------------------------
  // run length
  //--------------------------------------------------------------------------

  localparam int ResetCycles   = 2;
  localparam int MaxPeriod     = 16;
  // cycles to settle a change and then watch a handful of full periods
  localparam int PerFactor     = 10 * MaxPeriod;
  localparam int NumRand       = 20;
  localparam int Window        = 200;
  localparam int RunCycles     = 40 + 18 * PerFactor + NumRand * (PerFactor + 64)
                                 + 3 * Window + 400;
  localparam int TimeoutCycles = 2 * RunCycles;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         test_mode_en_i;
  logic                         cfg_we_i;
  chan_idx_t                    cfg_addr_i;
  chan_cfg_t                    cfg_wdata_i;
  logic [NumChannels-1:0]       cfg_busy_o;
  logic [NumChannels-1:0]       clk_o_o;
  edge_cnt_t [NumChannels-1:0]  edge_cnt_o;
  int                           chk_errs;
  int                           cycles = 0;
  int                           tests = 0;
  logic [31:0]                  lfsr_q = 32'hb22a_aebc;
  // factor that each channel holds after the writes that the bank must accept
  int                           cur_div [NumChannels];

  clk_div_bank i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .test_mode_en_i (test_mode_en_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_busy_o     (cfg_busy_o),
    .clk_o_o        (clk_o_o),
    .edge_cnt_o     (edge_cnt_o)
  );

  tb_clk_checker i_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .test_mode_i (test_mode_en_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_busy_i  (cfg_busy_o),
    .clk_div_i   (clk_o_o),
    .err_cnt_o   (chk_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // the run is cut off well past the sum of all test lengths
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  // fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic write_cfg(input int ch, input bit en, input int div);
    @(posedge clk_i);
    #1;
    cfg_we_i        = 1'b1;
    cfg_addr_i      = chan_idx_t'(ch);
    cfg_wdata_i.en  = en;
    cfg_wdata_i.div = div_t'(div);
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  // the timeout bounds this wait if ready never comes
  task automatic wait_idle(input int ch);
    while (cfg_busy_o[ch]) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // write an idle channel, a new factor must show up as busy in the next cycle
  task automatic write_checked(input int ch, input bit en, input int div);
    bit changed;
    changed = (div != cur_div[ch]);
    wait_idle(ch);
    write_cfg(ch, en, div);
    i_checker.check_range($sformatf("cfg_busy_o[%0d]", ch), int'(cfg_busy_o[ch]),
                          int'(changed), int'(changed));
    cur_div[ch] = div;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s finished, errors so far %0d", tests, name, chk_errs);
  endtask

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  initial begin
    int ch, div, gap, drop, c0, c1;
    bit changed;

    rst_ni         = 1'b0;
    test_mode_en_i = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = '0;
    cfg_wdata_i    = '0;
    for (int i = 0; i < NumChannels; i++) begin
      cur_div[i] = DefaultDiv;
    end
    wait_cycles(ResetCycles);
    rst_ni = 1'b1;

    // nothing runs until a channel is enabled
    repeat (20) begin
      wait_cycles(1);
      i_checker.check_range("clk_o_o", int'(clk_o_o), 0, 0);
    end
    for (int i = 0; i < NumChannels; i++) begin
      i_checker.check_range("edge_cnt_o", int'(edge_cnt_o[i]), 0, 0);
    end
    finish_test("reset state");

    for (int f = 2; f <= 14; f += 2) begin
      write_checked(f % NumChannels, 1'b1, f);
      wait_cycles(PerFactor);
    end
    finish_test("even factors");

    for (int f = 0; f <= 15; f++) begin
      if (f < 2 || f % 2 == 1) begin
        write_checked(f % NumChannels, 1'b1, f);
        wait_cycles(PerFactor);
      end
    end
    finish_test("odd factors and bypass");

    // random changes, some followed by a write that must be dropped as busy
    for (int n = 0; n < NumRand; n++) begin
      take_bits(2, ch);
      take_bits(4, div);
      take_bits(2, drop);
      take_bits(6, gap);
      changed = (div != cur_div[ch]);
      write_checked(ch, 1'b1, div);
      if (drop == 0 && changed) begin
        // presented in the first busy cycle, so the bank has to drop it
        cfg_we_i        = 1'b1;
        cfg_addr_i      = chan_idx_t'(ch);
        cfg_wdata_i.en  = 1'b1;
        cfg_wdata_i.div = div_t'((div + 1) % 16);
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b0;
      end
      wait_cycles(gap + PerFactor);
    end
    finish_test("random factor changes");

    for (int i = 0; i < NumChannels; i++) begin
      write_checked(i, 1'b1, 5);
    end
    wait_cycles(PerFactor);
    c0 = int'(edge_cnt_o[0]);
    wait_cycles(Window);
    c1 = int'(edge_cnt_o[0]);
    i_checker.check_range("edge_cnt_o[0] growth", (c1 - c0) & 8'hff,
                          Window / 5 - 2, Window / 5 + 2);
    write_checked(0, 1'b0, 5);
    wait_cycles(30);
    c0 = int'(edge_cnt_o[0]);
    repeat (Window) begin
      wait_cycles(1);
      i_checker.check_range("clk_o_o[0]", int'(clk_o_o[0]), 0, 0);
    end
    c1 = int'(edge_cnt_o[0]);
    i_checker.check_range("edge_cnt_o[0] after disable", (c1 - c0) & 8'hff, 0, 0);
    finish_test("disable and edge count");

    // test mode forwards clk_i on every channel, enabled or not
    test_mode_en_i = 1'b1;
    wait_cycles(4);
    repeat (16) begin
      @(posedge clk_i);
      #2;
      i_checker.check_range("clk_o_o high phase", int'(clk_o_o), 15, 15);
      @(negedge clk_i);
      #2;
      i_checker.check_range("clk_o_o low phase", int'(clk_o_o), 0, 0);
    end
    finish_test("test mode");

    $display("tests %0d, checker errors %0d, assertion failures %0d",
             tests, chk_errs, i_dut.i_asserts.fail_cnt);
    if (chk_errs == 0 && i_dut.i_asserts.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
